//--- logic/excp_pkg.sv
`default_nettype none

package excp_pkg;

    localparam int ECODE_W = 6;
    localparam int ESUB_W  = 9;
    localparam int HINT_W  = 2;
    localparam int PLV_W   = 2;

    // First-level exception codes
    localparam logic [ECODE_W-1:0] ECODE_PIL  = 6'h01;
    localparam logic [ECODE_W-1:0] ECODE_PIS  = 6'h02;
    localparam logic [ECODE_W-1:0] ECODE_PIF  = 6'h03;
    localparam logic [ECODE_W-1:0] ECODE_PME  = 6'h04;
    localparam logic [ECODE_W-1:0] ECODE_PPI  = 6'h07;
    localparam logic [ECODE_W-1:0] ECODE_ADE  = 6'h08;
    localparam logic [ECODE_W-1:0] ECODE_ALE  = 6'h09;
    localparam logic [ECODE_W-1:0] ECODE_SYS  = 6'h0b;
    localparam logic [ECODE_W-1:0] ECODE_BRK  = 6'h0c;
    localparam logic [ECODE_W-1:0] ECODE_INE  = 6'h0d;
    localparam logic [ECODE_W-1:0] ECODE_IPE  = 6'h0e;
    localparam logic [ECODE_W-1:0] ECODE_TLBR = 6'h3f;

    localparam logic [ESUB_W-1:0] ESUBCODE_ADEF = 9'd0;
    localparam logic [ESUB_W-1:0] ESUBCODE_ADEM = 9'd1;

    localparam logic [HINT_W-1:0] HINT_NONE    = 2'd0;
    localparam logic [HINT_W-1:0] HINT_SYSCALL = 2'd1;
    localparam logic [HINT_W-1:0] HINT_INVALID = 2'd2;

    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;

    localparam logic [PLV_W-1:0] PLV_USER = 2'd3;

    localparam int TLB_ENTRIES   = 8;
    localparam int TLB_IDX_W     = 3;
    localparam int VPPN_W        = 19;
    localparam int VPN_LSB       = 13;
    localparam int USER_VA_LIMIT = 31;

    // Opcode fields of the decoded subset
    localparam logic [9:0]  OP10_LD_B    = 10'h0a0;
    localparam logic [9:0]  OP10_LD_H    = 10'h0a1;
    localparam logic [9:0]  OP10_LD_W    = 10'h0a2;
    localparam logic [9:0]  OP10_ST_B    = 10'h0a4;
    localparam logic [9:0]  OP10_ST_H    = 10'h0a5;
    localparam logic [9:0]  OP10_ST_W    = 10'h0a6;
    localparam logic [9:0]  OP10_CACOP   = 10'h018;
    localparam logic [14:0] OP15_SYSBRK  = 15'h0015;
    localparam logic [16:0] OP17_INVTLB  = 17'h00c93;
    localparam logic [31:0] INST_ERTN    = 32'h0648_3800;
    localparam logic [31:0] INST_TLBFILL = 32'h0648_3400;
    localparam logic [31:0] INST_TLBWR   = 32'h0648_3000;
    localparam logic [31:0] INST_NOP     = 32'h0340_0000;
    localparam logic [4:0]  INVTLB_OP_MAX = 5'd6;

    // Low 26 bits of the instruction, two readings
    typedef union packed {
        struct packed {
            logic [8:0]  pad;
            logic        sys_sel;   // 1 SYSCALL, 0 BREAK
            logic        rsvd;
            logic [14:0] code;
        } sys;
        struct packed {
            logic [10:0] pad;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  op;
        } invtlb;
    } inst_tail_u;

endpackage

`default_nettype wire

//--- logic/excp_ifs.sv
`default_nettype none

interface decode_if;
    import excp_pkg::*;

    logic              mem_valid;
    logic              mem_write;
    logic [1:0]        mem_size;
    logic              cacop;
    logic              invtlb_en;
    logic              priv_inst;
    logic              ertn;
    logic [HINT_W-1:0] exception_hint;
    inst_tail_u        tail;

    modport src (output mem_valid, mem_write, mem_size, cacop, invtlb_en, priv_inst, ertn,
                 output exception_hint, tail);
    modport dst (input mem_valid, mem_write, mem_size, cacop, invtlb_en, priv_inst, ertn,
                 input exception_hint, tail);
endinterface

interface excp_flow_if;
    logic adef;
    logic itlbr;
    logic pif;
    logic ippi;
    logic ale;
    logic adem;

    modport src (output adef, itlbr, pif, ippi, ale, adem);
    modport dst (input adef, itlbr, pif, ippi, ale, adem);
endinterface

interface tlb_resp_if;
    import excp_pkg::*;

    logic [VPPN_W-1:0] vpn;
    logic              found;
    logic              v;
    logic              d;
    logic [PLV_W-1:0]  plv;

    modport requester (output vpn, input found, v, d, plv);
    modport responder (input vpn, output found, v, d, plv);
endinterface

`default_nettype wire

//--- logic/inst_decode.sv
`default_nettype none

module inst_decode (
    input  logic [31:0] inst_i,
    decode_if.src       dec
);
    import excp_pkg::*;

    always_comb begin
        dec.mem_valid      = 1'b0;
        dec.mem_write      = 1'b0;
        dec.mem_size       = inst_i[23:22];   // Width field of LD/ST
        dec.cacop          = 1'b0;
        dec.invtlb_en      = 1'b0;
        dec.priv_inst      = 1'b0;
        dec.ertn           = 1'b0;
        dec.exception_hint = HINT_NONE;
        dec.tail           = inst_i[25:0];

        case (inst_i[31:22])
            OP10_LD_B, OP10_LD_H, OP10_LD_W: begin
                dec.mem_valid = 1'b1;
            end
            OP10_ST_B, OP10_ST_H, OP10_ST_W: begin
                dec.mem_valid = 1'b1;
                dec.mem_write = 1'b1;
            end
            OP10_CACOP: begin
                dec.cacop     = 1'b1;
                dec.priv_inst = 1'b1;
            end
            default: begin
                if (inst_i[31:17] == OP15_SYSBRK && !inst_i[15]) begin
                    dec.exception_hint = HINT_SYSCALL;   // SYSCALL or BREAK
                end else if (inst_i[31:15] == OP17_INVTLB) begin
                    dec.invtlb_en = 1'b1;
                    dec.priv_inst = 1'b1;
                end else if (inst_i == INST_ERTN) begin
                    dec.ertn      = 1'b1;
                    dec.priv_inst = 1'b1;
                end else if (inst_i == INST_TLBFILL || inst_i == INST_TLBWR) begin
                    dec.priv_inst = 1'b1;
                end else if (inst_i != INST_NOP) begin
                    dec.exception_hint = HINT_INVALID;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/addr_check.sv
`default_nettype none

module addr_check (
    input  logic [31:0]                pc_i,
    input  logic [31:0]                lsu_va_i,
    input  logic [excp_pkg::PLV_W-1:0] plv_i,
    input  logic                       trans_en_i,
    decode_if.dst                      dec,
    tlb_resp_if.requester              fetch_tlb,
    tlb_resp_if.requester              data_tlb,
    excp_flow_if.src                   flow
);
    import excp_pkg::*;

    logic user_mode;
    logic misaligned;

    assign user_mode = (plv_i == PLV_USER);

    assign fetch_tlb.vpn = pc_i[31:VPN_LSB];
    assign data_tlb.vpn  = lsu_va_i[31:VPN_LSB];

    always_comb begin
        case (dec.mem_size)
            SIZE_B:  misaligned = 1'b0;
            SIZE_H:  misaligned = lsu_va_i[0];
            SIZE_W:  misaligned = |lsu_va_i[1:0];
            default: misaligned = 1'b1;   // Reserved width
        endcase
    end

    // Fetch side
    assign flow.adef  = (|pc_i[1:0]) || (pc_i[USER_VA_LIMIT] && user_mode);
    assign flow.itlbr = trans_en_i && !fetch_tlb.found;
    assign flow.pif   = trans_en_i && fetch_tlb.found && !fetch_tlb.v;
    assign flow.ippi  = trans_en_i && fetch_tlb.found && fetch_tlb.v &&
                        (plv_i > fetch_tlb.plv);

    // Data side, memory instructions only
    assign flow.ale  = dec.mem_valid && misaligned;
    assign flow.adem = (dec.mem_valid || dec.cacop) && lsu_va_i[USER_VA_LIMIT] && user_mode;

endmodule

`default_nettype wire

//--- logic/tlb_array.sv
`default_nettype none

module tlb_array (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            we_i,
    input  logic [excp_pkg::TLB_IDX_W-1:0]  idx_i,
    input  logic [excp_pkg::VPPN_W-1:0]     vppn_i,
    input  logic                            v_i,
    input  logic                            d_i,
    input  logic [excp_pkg::PLV_W-1:0]      plv_i,
    tlb_resp_if.responder                   fetch_tlb,
    tlb_resp_if.responder                   data_tlb
);
    import excp_pkg::*;

    logic [TLB_ENTRIES-1:0] ent_e;
    logic [VPPN_W-1:0]      ent_vppn [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] ent_v;
    logic [TLB_ENTRIES-1:0] ent_d;
    logic [PLV_W-1:0]       ent_plv [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] f_hit;
    logic [TLB_ENTRIES-1:0] d_hit;
    logic [TLB_IDX_W-1:0]   f_idx;
    logic [TLB_IDX_W-1:0]   d_idx;

    // Lowest matching index wins
    function automatic logic [TLB_IDX_W-1:0] first_hit(input logic [TLB_ENTRIES-1:0] hit);
        logic [TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                idx = i[TLB_IDX_W-1:0];
            end
        end
        return idx;
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ent_e <= '0;
        end else if (we_i) begin
            ent_e[idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            ent_vppn[idx_i] <= vppn_i;
            ent_v[idx_i]    <= v_i;
            ent_d[idx_i]    <= d_i;
            ent_plv[idx_i]  <= plv_i;
        end
    end

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_cmp
        assign f_hit[i] = ent_e[i] && (ent_vppn[i] == fetch_tlb.vpn);
        assign d_hit[i] = ent_e[i] && (ent_vppn[i] == data_tlb.vpn);
    end

    assign f_idx = first_hit(f_hit);
    assign d_idx = first_hit(d_hit);

    assign fetch_tlb.found = |f_hit;
    assign fetch_tlb.v     = (|f_hit) && ent_v[f_idx];
    assign fetch_tlb.d     = (|f_hit) && ent_d[f_idx];
    assign fetch_tlb.plv   = ent_plv[f_idx];

    assign data_tlb.found = |d_hit;
    assign data_tlb.v     = (|d_hit) && ent_v[d_idx];
    assign data_tlb.d     = (|d_hit) && ent_d[d_idx];
    assign data_tlb.plv   = ent_plv[d_idx];

endmodule

`default_nettype wire

//--- logic/excp_handler.sv
`default_nettype none

module excp_handler (
    decode_if.dst                         dec,
    excp_flow_if.dst                      flow,
    tlb_resp_if.requester                 data_tlb,
    input  logic [31:0]                   vpc_i,
    input  logic [31:0]                   vlsu_i,
    input  logic                          trans_en_i,
    input  logic [excp_pkg::PLV_W-1:0]    plv_i,
    output logic [excp_pkg::ECODE_W-1:0]  ecode_o,
    output logic [excp_pkg::ESUB_W-1:0]   esubcode_o,
    output logic                          excp_trigger_o,
    output logic [31:0]                   bad_va_o,
    output logic                          va_error_o,
    output logic                          tlbrefill_o,
    output logic                          tlbehi_update_o,
    output logic                          ipe_o
);
    import excp_pkg::*;

    logic mem_op;
    logic bad_invtlb;
    logic dmap;

    assign mem_op     = dec.mem_valid || dec.cacop;
    assign bad_invtlb = dec.invtlb_en && (dec.tail.invtlb.op > INVTLB_OP_MAX);
    assign dmap       = trans_en_i && mem_op;   // Data access goes through the TLB

    always_comb begin
        ecode_o         = '0;
        esubcode_o      = '0;
        excp_trigger_o  = 1'b1;
        bad_va_o        = vpc_i;
        va_error_o      = 1'b0;
        tlbrefill_o     = 1'b0;
        tlbehi_update_o = 1'b0;
        ipe_o           = 1'b0;

        if (flow.adef) begin
            ecode_o    = ECODE_ADE;
            esubcode_o = ESUBCODE_ADEF;
            va_error_o = 1'b1;
        end else if (flow.itlbr) begin
            ecode_o         = ECODE_TLBR;
            va_error_o      = 1'b1;
            tlbrefill_o     = 1'b1;
            tlbehi_update_o = 1'b1;
        end else if (flow.pif || flow.ippi) begin
            ecode_o         = flow.pif ? ECODE_PIF : ECODE_PPI;
            va_error_o      = 1'b1;
            tlbehi_update_o = 1'b1;
        end else if (dec.exception_hint == HINT_SYSCALL) begin
            ecode_o = dec.tail.sys.sys_sel ? ECODE_SYS : ECODE_BRK;
        end else if (dec.exception_hint == HINT_INVALID || bad_invtlb) begin
            ecode_o = ECODE_INE;
        end else if (dec.priv_inst && plv_i == PLV_USER) begin
            ecode_o = ECODE_IPE;
            ipe_o   = 1'b1;
        end else if (flow.ale) begin
            ecode_o    = ECODE_ALE;
            bad_va_o   = vlsu_i;
            va_error_o = 1'b1;
        end else if (flow.adem) begin
            ecode_o    = ECODE_ADE;
            esubcode_o = ESUBCODE_ADEM;
            bad_va_o   = vlsu_i;
            va_error_o = 1'b1;
        end else if (dmap && !data_tlb.found) begin
            ecode_o         = ECODE_TLBR;
            bad_va_o        = vlsu_i;
            va_error_o      = 1'b1;
            tlbrefill_o     = 1'b1;
            tlbehi_update_o = 1'b1;
        end else if (dmap && !data_tlb.v) begin
            ecode_o         = dec.mem_write ? ECODE_PIS : ECODE_PIL;
            bad_va_o        = vlsu_i;
            va_error_o      = 1'b1;
            tlbehi_update_o = 1'b1;
        end else if (trans_en_i && dec.mem_valid && plv_i > data_tlb.plv) begin
            ecode_o         = ECODE_PPI;
            bad_va_o        = vlsu_i;
            va_error_o      = 1'b1;
            tlbehi_update_o = 1'b1;
        end else if (trans_en_i && dec.mem_write && !data_tlb.d) begin
            ecode_o         = ECODE_PME;   // Store to clean page
            bad_va_o        = vlsu_i;
            va_error_o      = 1'b1;
            tlbehi_update_o = 1'b1;
        end else begin
            excp_trigger_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/excp_csr.sv
`default_nettype none

module excp_csr (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          valid_i,
    input  logic                          mode_we_i,
    input  logic [excp_pkg::PLV_W-1:0]    mode_plv_i,
    input  logic                          mode_pg_i,
    decode_if.dst                         dec,
    input  logic                          excp_trigger_i,
    input  logic [excp_pkg::ECODE_W-1:0]  ecode_i,
    input  logic [excp_pkg::ESUB_W-1:0]   esubcode_i,
    input  logic [31:0]                   bad_va_i,
    input  logic                          va_error_i,
    input  logic                          tlbrefill_i,
    input  logic                          tlbehi_update_i,
    input  logic [31:0]                   pc_i,
    output logic [excp_pkg::PLV_W-1:0]    plv_o,
    output logic                          trans_en_o,
    output logic [31:0]                   era_o,
    output logic [31:0]                   estat_o,
    output logic [31:0]                   badv_o,
    output logic [31:0]                   tlbehi_o
);
    import excp_pkg::*;

    logic [PLV_W-1:0] plv_q;
    logic             pg_q;
    logic [PLV_W-1:0] pplv_q;   // PRMD
    logic             ppg_q;
    logic             commit;
    logic             ertn_go;

    assign commit  = valid_i && excp_trigger_i;
    assign ertn_go = valid_i && dec.ertn && !excp_trigger_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            plv_q    <= '0;
            pg_q     <= 1'b0;
            pplv_q   <= '0;
            ppg_q    <= 1'b0;
            era_o    <= '0;
            estat_o  <= '0;
            badv_o   <= '0;
            tlbehi_o <= '0;
        end else if (commit) begin
            pplv_q  <= plv_q;
            ppg_q   <= pg_q;
            plv_q   <= '0;
            era_o   <= pc_i;
            estat_o <= {1'b0, esubcode_i, ecode_i, 16'h0000};
            if (tlbrefill_i) begin
                pg_q <= 1'b0;   // Refill handler runs untranslated
            end
            if (va_error_i) begin
                badv_o <= bad_va_i;
            end
            if (tlbehi_update_i) begin
                tlbehi_o <= {bad_va_i[31:VPN_LSB], {VPN_LSB{1'b0}}};
            end
        end else if (ertn_go) begin
            plv_q <= pplv_q;
            pg_q  <= ppg_q;
        end else if (mode_we_i) begin
            plv_q <= mode_plv_i;
            pg_q  <= mode_pg_i;
        end
    end

    assign plv_o      = plv_q;
    assign trans_en_o = pg_q;

endmodule

`default_nettype wire

//--- logic/excp_stage_top.sv
`default_nettype none

module excp_stage_top (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          inst_valid_i,
    input  logic [31:0]                   inst_i,
    input  logic [31:0]                   pc_i,
    input  logic [31:0]                   lsu_va_i,
    input  logic                          mode_we_i,
    input  logic [excp_pkg::PLV_W-1:0]    mode_plv_i,
    input  logic                          mode_pg_i,
    input  logic                          tlb_we_i,
    input  logic [excp_pkg::TLB_IDX_W-1:0] tlb_idx_i,
    input  logic [excp_pkg::VPPN_W-1:0]   tlb_vppn_i,
    input  logic                          tlb_v_i,
    input  logic                          tlb_d_i,
    input  logic [excp_pkg::PLV_W-1:0]    tlb_plv_i,
    output logic                          excp_o,
    output logic [excp_pkg::ECODE_W-1:0]  ecode_o,
    output logic [excp_pkg::ESUB_W-1:0]   esubcode_o,
    output logic [excp_pkg::PLV_W-1:0]    plv_o,
    output logic [31:0]                   era_o,
    output logic [31:0]                   badv_o,
    output logic [31:0]                   tlbehi_o
);
    import excp_pkg::*;

    decode_if    dec_bus ();
    excp_flow_if flow_bus ();
    tlb_resp_if  fetch_tlb ();
    tlb_resp_if  data_tlb ();

    logic        trans_en;
    logic        excp_trigger;
    logic [31:0] bad_va;
    logic        va_error;
    logic        tlbrefill;
    logic        tlbehi_update;

    assign excp_o = inst_valid_i && excp_trigger;

    inst_decode u_decode (
        .inst_i (inst_i),
        .dec    (dec_bus)
    );

    addr_check u_addr_check (
        .pc_i       (pc_i),
        .lsu_va_i   (lsu_va_i),
        .plv_i      (plv_o),
        .trans_en_i (trans_en),
        .dec        (dec_bus),
        .fetch_tlb  (fetch_tlb),
        .data_tlb   (data_tlb),
        .flow       (flow_bus)
    );

    tlb_array u_tlb (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .we_i      (tlb_we_i),
        .idx_i     (tlb_idx_i),
        .vppn_i    (tlb_vppn_i),
        .v_i       (tlb_v_i),
        .d_i       (tlb_d_i),
        .plv_i     (tlb_plv_i),
        .fetch_tlb (fetch_tlb),
        .data_tlb  (data_tlb)
    );

    excp_handler u_handler (
        .dec             (dec_bus),
        .flow            (flow_bus),
        .data_tlb        (data_tlb),
        .vpc_i           (pc_i),
        .vlsu_i          (lsu_va_i),
        .trans_en_i      (trans_en),
        .plv_i           (plv_o),
        .ecode_o         (ecode_o),
        .esubcode_o      (esubcode_o),
        .excp_trigger_o  (excp_trigger),
        .bad_va_o        (bad_va),
        .va_error_o      (va_error),
        .tlbrefill_o     (tlbrefill),
        .tlbehi_update_o (tlbehi_update),
        .ipe_o           ()
    );

    excp_csr u_csr (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .valid_i         (inst_valid_i),
        .mode_we_i       (mode_we_i),
        .mode_plv_i      (mode_plv_i),
        .mode_pg_i       (mode_pg_i),
        .dec             (dec_bus),
        .excp_trigger_i  (excp_trigger),
        .ecode_i         (ecode_o),
        .esubcode_i      (esubcode_o),
        .bad_va_i        (bad_va),
        .va_error_i      (va_error),
        .tlbrefill_i     (tlbrefill),
        .tlbehi_update_i (tlbehi_update),
        .pc_i            (pc_i),
        .plv_o           (plv_o),
        .trans_en_o      (trans_en),
        .era_o           (era_o),
        .estat_o         (),
        .badv_o          (badv_o),
        .tlbehi_o        (tlbehi_o)
    );

endmodule

`default_nettype wire

//--- verif/excp_stage_tb.sv
`default_nettype none

module excp_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import excp_pkg::*;

    localparam int    MAX_LINES    = 200;
    localparam int    RESET_CYCLES = 16;
    localparam string STIM_FILE    = "verif/excp_stimulus.dat";

    logic                 clk_i;
    logic                 rst_i;
    logic                 inst_valid_i;
    logic [31:0]          inst_i;
    logic [31:0]          pc_i;
    logic [31:0]          lsu_va_i;
    logic                 mode_we_i;
    logic [PLV_W-1:0]     mode_plv_i;
    logic                 mode_pg_i;
    logic                 tlb_we_i;
    logic [TLB_IDX_W-1:0] tlb_idx_i;
    logic [VPPN_W-1:0]    tlb_vppn_i;
    logic                 tlb_v_i;
    logic                 tlb_d_i;
    logic [PLV_W-1:0]     tlb_plv_i;
    logic                 excp_o;
    logic [ECODE_W-1:0]   ecode_o;
    logic [ESUB_W-1:0]    esubcode_o;
    logic [PLV_W-1:0]     plv_o;
    logic [31:0]          era_o;
    logic [31:0]          badv_o;
    logic [31:0]          tlbehi_o;

    int          fd;
    int          n;
    int          lines_read;
    int          records;
    byte         tag;
    string       line;
    logic [31:0] col [9];   // Fields of the current record
    logic        too_long;

    excp_stage_top dut_i (
        .clk_i (clk_i), .rst_i (rst_i), .inst_valid_i (inst_valid_i), .inst_i (inst_i),
        .pc_i (pc_i), .lsu_va_i (lsu_va_i), .mode_we_i (mode_we_i),
        .mode_plv_i (mode_plv_i), .mode_pg_i (mode_pg_i), .tlb_we_i (tlb_we_i),
        .tlb_idx_i (tlb_idx_i), .tlb_vppn_i (tlb_vppn_i), .tlb_v_i (tlb_v_i),
        .tlb_d_i (tlb_d_i), .tlb_plv_i (tlb_plv_i), .excp_o (excp_o), .ecode_o (ecode_o),
        .esubcode_o (esubcode_o), .plv_o (plv_o), .era_o (era_o), .badv_o (badv_o),
        .tlbehi_o (tlbehi_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic fail_run();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        fail_run();
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_ecode(input string name, input logic [ECODE_W-1:0] got,
                               input logic [ECODE_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_esub(input string name, input logic [ESUB_W-1:0] got,
                              input logic [ESUB_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_plv(input string name, input logic [PLV_W-1:0] got,
                             input logic [PLV_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) begin
            abort_run("malformed record in stimulus file");
        end
    endtask

    task automatic load_tlb_entry();
        tlb_we_i   = 1'b1;
        tlb_idx_i  = col[0][TLB_IDX_W-1:0];
        tlb_vppn_i = col[1][VPPN_W-1:0];
        tlb_v_i    = col[2][0];
        tlb_d_i    = col[3][0];
        tlb_plv_i  = col[4][PLV_W-1:0];
        @(negedge clk_i);
        tlb_we_i = 1'b0;
    endtask

    task automatic load_mode();
        mode_we_i  = 1'b1;
        mode_plv_i = col[0][PLV_W-1:0];
        mode_pg_i  = col[1][0];
        @(negedge clk_i);
        mode_we_i = 1'b0;
    endtask

    task automatic run_inst();
        inst_valid_i = 1'b1;
        inst_i       = col[0];
        pc_i         = col[1];
        lsu_va_i     = col[2];
        #40;   // Just before the rising edge
        check_flag("excp_o", excp_o, col[3][0]);
        if (col[3][0]) begin
            check_ecode("ecode_o", ecode_o, col[4][ECODE_W-1:0]);
            check_esub("esubcode_o", esubcode_o, col[5][ESUB_W-1:0]);
        end
        @(negedge clk_i);
        inst_valid_i = 1'b0;
        if (col[3][0]) begin
            check_word("era_o", era_o, col[1]);
        end
        check_word("badv_o", badv_o, col[6]);
        check_word("tlbehi_o", tlbehi_o, col[7]);
        check_plv("plv_o", plv_o, col[8][PLV_W-1:0]);
    endtask

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        lsu_va_i     = '0;
        mode_we_i    = 1'b0;
        mode_plv_i   = '0;
        mode_pg_i    = 1'b0;
        tlb_we_i     = 1'b0;
        tlb_idx_i    = '0;
        tlb_vppn_i   = '0;
        tlb_v_i      = 1'b0;
        tlb_d_i      = 1'b0;
        tlb_plv_i    = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_flag("excp_o", excp_o, 1'b0);
        check_plv("plv_o", plv_o, '0);
        check_word("era_o", era_o, '0);
        check_word("badv_o", badv_o, '0);
        check_word("tlbehi_o", tlbehi_o, '0);

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end
        lines_read = 0;
        records    = 0;
        while (!$feof(fd) && lines_read < MAX_LINES) begin
            n = $fgets(line, fd);
            lines_read++;
            if (n > 0) begin
                tag = line.getc(0);
                case (tag)
                    "F": begin
                        n = $sscanf(line, "F %h %h %h %h %h", col[0], col[1], col[2],
                                    col[3], col[4]);
                        expect_fields(n, 5);
                        load_tlb_entry();
                        records++;
                    end
                    "M": begin
                        n = $sscanf(line, "M %h %h", col[0], col[1]);
                        expect_fields(n, 2);
                        load_mode();
                        records++;
                    end
                    "I": begin
                        n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h", col[0], col[1],
                                    col[2], col[3], col[4], col[5], col[6], col[7], col[8]);
                        expect_fields(n, 9);
                        run_inst();
                        records++;
                    end
                    "#", " ", 8'h0a, 8'h0d: begin
                    end
                    default: abort_run("unknown record type in stimulus file");
                endcase
            end
        end
        too_long = (lines_read >= MAX_LINES) && !$feof(fd);
        $fclose(fd);

        if (too_long || records == 0) begin
            abort_run("stimulus file too long or without records");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verif/excp_stimulus.dat
# F idx vppn v d plv | M plv pg
# I inst pc va excp ecode esub badv tlbehi plv
I 28800000 1c000000 00001000 0 00 000 00000000 00000000 0
I 29800000 1c000004 00001004 0 00 000 00000000 00000000 0
I 28000000 1c000008 00001003 0 00 000 00000000 00000000 0
I 28400000 1c00000c 00001002 0 00 000 00000000 00000000 0
I 03400000 1c000010 00000000 0 00 000 00000000 00000000 0
I 002b0000 1c000014 00000000 1 0b 000 00000000 00000000 0
I 002a0000 1c000018 00000000 1 0c 000 00000000 00000000 0
I ffffffff 1c00001c 00000000 1 0d 000 00000000 00000000 0
I 06498007 1c000020 00000000 1 0d 000 00000000 00000000 0
I 06498000 1c000024 00000000 0 00 000 00000000 00000000 0
I 03400000 1c000026 00000000 1 08 000 1c000026 00000000 0
I 28800000 1c000028 00002002 1 09 000 00002002 00000000 0
I 28800000 1c00002a 00002001 1 08 000 1c00002a 00000000 0
M 3 0
I 28800000 1c000030 80000000 1 08 001 80000000 00000000 0
I 06483800 1c000034 00000000 0 00 000 80000000 00000000 3
I 06483800 1c000038 00000000 1 0e 000 80000000 00000000 0
I 06483800 1c00003c 00000000 0 00 000 80000000 00000000 3
I 06483400 1c000040 00000000 1 0e 000 80000000 00000000 0
I 06483800 1c000044 00000000 0 00 000 80000000 00000000 3
I 29800000 80000000 80000004 1 08 000 80000000 00000000 0
F 0 0e000 1 0 3
M 0 1
I 28800000 1c000100 00402abc 1 3f 000 00402abc 00402000 0
I 28800000 1c000104 00402abc 0 00 000 00402abc 00402000 0
F 1 00100 0 0 3
F 2 00101 1 0 0
F 3 00102 1 0 3
F 4 00103 1 1 3
M 3 1
I 28800000 1c000200 00200010 1 01 000 00200010 00200000 0
I 06483800 1c000204 00000000 0 00 000 00200010 00200000 3
I 29800000 1c000208 00200020 1 02 000 00200020 00200000 0
I 06483800 1c00020c 00000000 0 00 000 00200020 00200000 3
I 28800000 1c000210 00202004 1 07 000 00202004 00202000 0
I 06483800 1c000214 00000000 0 00 000 00202004 00202000 3
I 29800000 1c000218 00204008 1 04 000 00204008 00204000 0
I 06483800 1c00021c 00000000 0 00 000 00204008 00204000 3
I 29800000 1c000220 0020600c 0 00 000 00204008 00204000 3
I 28800000 1c000224 00206010 0 00 000 00204008 00204000 3

//--- compile.f
logic/excp_pkg.sv
logic/excp_ifs.sv
logic/inst_decode.sv
logic/addr_check.sv
logic/tlb_array.sv
logic/excp_handler.sv
logic/excp_csr.sv
logic/excp_stage_top.sv
verif/excp_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module excp_stage_tb \
    -f compile.f -o excp_sim &&
./obj_dir/excp_sim || exit 1
